// File: verilog.f
src/core_pkg.sv
src/instr_decode.sv
src/issue_queue.sv
src/reg_file.sv
src/alu.sv
src/exec_unit.sv
src/alu_core.sv
test/tb_alu_core.sv

// File: test/tb_alu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_alu_core;
    import core_pkg::*;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  in_valid;
    logic [xlen-1:0]       in_instr;
    logic                  in_credit;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic [xlen-1:0]       wb_pc;
    logic                  wb_illegal;
    logic                  wb_credit = 1'b0;

    int seed = 32'h59c3_a256;
    int errors;
    int sent_count;
    int credits_back;
    int wb_seen;
    int credits_returned;
    int hold_wb;
    logic hold;
    logic stall_window;
    logic gap_next;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] ref_regs [num_regs];
    logic [xlen-1:0] sent_instr [$];
    logic [xlen-1:0] sent_pc [$];

    alu_core i_alu_core (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc),
        .wb_illegal (wb_illegal),
        .wb_credit  (wb_credit)
    );

    initial begin
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [xlen-1:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [xlen-1:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    // rv32i alu semantics, illegal encodings give zero.
    function automatic logic [xlen-1:0] expected_result(input logic [xlen-1:0] instr,
            input logic [xlen-1:0] a, input logic [xlen-1:0] rs2_val, output logic illegal);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        opc = instr[6:0];
        f3 = instr[14:12];
        f7 = instr[31:25];
        b = (opc == 7'h13) ? {{20{instr[31]}}, instr[31:20]} : rs2_val;
        res = '0;
        illegal = 1'b0;
        if (opc != 7'h33 && opc != 7'h13) begin
            illegal = 1'b1;
        end else if (opc == 7'h33 && f7 != 7'h00
                     && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
            illegal = 1'b1;
        end else if (opc == 7'h13 && f3 == 3'd1 && f7 != 7'h00) begin
            illegal = 1'b1;
        end else if (opc == 7'h13 && f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) begin
            illegal = 1'b1;
        end else begin
            case (f3)
                3'd0: res = (opc == 7'h33 && f7 == 7'h20) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    if (f7 == 7'h20) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
        return res;
    endfunction

    // small register set so that results feed later instructions.
    function automatic logic [xlen-1:0] random_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [6:0]  f7;
        r = $random(seed);
        s = $random(seed);
        f7 = r[9] ? 7'h20 : 7'h00;
        if (r[12:10] == 3'd0) begin
            f7 = s[6:0];
        end
        if (r[20:17] == 4'd0) begin
            return {s[31:7], 7'h03};
        end else if (r[13]) begin
            return rtype_word(f7, {2'b00, r[8:6]}, {2'b00, r[5:3]}, r[16:14], {2'b00, r[2:0]});
        end else if (r[16:14] == 3'd1 || r[16:14] == 3'd5) begin
            return itype_word({f7, s[11:7]}, {2'b00, r[5:3]}, r[16:14], {2'b00, r[2:0]});
        end
        return itype_word(s[31:20], {2'b00, r[5:3]}, r[16:14], {2'b00, r[2:0]});
    endfunction

    function automatic int src_credits();
        return queue_depth + credits_back - sent_count;
    endfunction

    task automatic abort_run(input string what);
        errors++;
        $display("%s", what);
        $display("errors: %0d, sent: %0d, completed: %0d", errors, sent_count, wb_seen);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic send_instr(input logic [xlen-1:0] instr);
        int waited;
        waited = 0;
        while (src_credits() <= 0) begin
            @(negedge clk);
            waited++;
            if (waited > 200) begin
                abort_run("timed out waiting for an issue queue credit");
            end
        end
        in_valid = 1'b1;
        in_instr = instr;
        sent_instr.push_back(instr);
        sent_pc.push_back(next_pc);
        next_pc += 32'd4;
        sent_count++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while (sent_instr.size() != 0 || wb_seen != credits_returned) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                abort_run("timed out waiting for outstanding instructions to complete");
            end
        end
        // let the last returned credit land.
        @(negedge clk);
    endtask

    task automatic check_completion();
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] exp_data;
        logic            exp_illegal;
        if (sent_instr.size() == 0) begin
            errors++;
            $display("writeback seen with no instruction outstanding");
        end else begin
            instr = sent_instr.pop_front();
            pc = sent_pc.pop_front();
            exp_data = expected_result(instr, ref_regs[instr[19:15]], ref_regs[instr[24:20]],
                                       exp_illegal);
            a_wb_data: assert (wb_data == exp_data) else begin
                errors++;
                $display("CHECK FAILED wb_data expected %h got %h", exp_data, wb_data);
            end
            a_wb_pc: assert (wb_pc == pc) else begin
                errors++;
                $display("CHECK FAILED wb_pc expected %h got %h", pc, wb_pc);
            end
            a_wb_rd: assert (wb_rd == instr[11:7]) else begin
                errors++;
                $display("CHECK FAILED wb_rd expected %h got %h", instr[11:7], wb_rd);
            end
            a_wb_illegal: assert (wb_illegal == exp_illegal) else begin
                errors++;
                $display("CHECK FAILED wb_illegal expected %h got %h", exp_illegal, wb_illegal);
            end
            if (!exp_illegal && instr[11:7] != 5'd0) begin
                ref_regs[instr[11:7]] = exp_data;
            end
        end
    endtask

    // monitor, samples registered outputs at the rising edge.
    always @(posedge clk) begin
        if (rstn) begin
            if (in_credit) begin
                credits_back++;
            end
            if (wb_valid) begin
                wb_seen++;
                if (hold) begin
                    hold_wb++;
                end
                check_completion();
            end
        end
        gap_next = (($random(seed) & 3) == 0);
    end

    // writeback sink, one credit back per completion with random gaps.
    always @(negedge clk) begin
        if (rstn && !hold && !gap_next && (wb_seen > credits_returned)) begin
            wb_credit <= 1'b1;
            credits_returned++;
        end else begin
            wb_credit <= 1'b0;
        end
    end

    a_idle_before_send: assert property (@(posedge clk) disable iff (!rstn)
        (sent_count == 0) |-> (!wb_valid && !in_credit))
        else begin
            errors++;
            $display("CHECK FAILED wb_valid expected 0 got %h, in_credit expected 0 got %h",
                     $sampled(wb_valid), $sampled(in_credit));
        end

    a_credit_with_wb: assert property (@(posedge clk) disable iff (!rstn)
        in_credit == wb_valid)
        else begin
            errors++;
            $display("CHECK FAILED in_credit expected %h got %h",
                     $sampled(wb_valid), $sampled(in_credit));
        end

    a_stall_quiet: assert property (@(posedge clk) disable iff (!rstn)
        stall_window |-> (!wb_valid && !in_credit))
        else begin
            errors++;
            $display("CHECK FAILED wb_valid expected 0 got %h, in_credit expected 0 got %h",
                     $sampled(wb_valid), $sampled(in_credit));
        end

    initial begin
        rstn = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        errors = 0;
        sent_count = 0;
        credits_back = 0;
        wb_seen = 0;
        credits_returned = 0;
        hold_wb = 0;
        hold = 1'b0;
        stall_window = 1'b0;
        gap_next = 1'b0;
        next_pc = '0;
        for (int i = 0; i < num_regs; i++) begin
            ref_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);

        // register forms, then immediate forms.
        send_instr(itype_word(12'h123, 5'd0, 3'd0, 5'd1));
        send_instr(itype_word(12'hffb, 5'd0, 3'd0, 5'd2));
        send_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        send_instr(rtype_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
        send_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'd7, 5'd5));
        send_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'd6, 5'd6));
        send_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'd4, 5'd7));
        send_instr(rtype_word(7'h00, 5'd1, 5'd2, 3'd2, 5'd8));
        send_instr(rtype_word(7'h00, 5'd1, 5'd2, 3'd3, 5'd9));
        send_instr(rtype_word(7'h00, 5'd1, 5'd1, 3'd1, 5'd10));
        send_instr(rtype_word(7'h00, 5'd1, 5'd2, 3'd5, 5'd11));
        send_instr(rtype_word(7'h20, 5'd1, 5'd2, 3'd5, 5'd12));
        send_instr(itype_word(12'hffb, 5'd1, 3'd2, 5'd8));
        send_instr(itype_word(12'hffb, 5'd1, 3'd3, 5'd9));
        send_instr(itype_word(12'h0f0, 5'd1, 3'd4, 5'd5));
        send_instr(itype_word(12'h80f, 5'd1, 3'd6, 5'd6));
        send_instr(itype_word(12'h0ff, 5'd2, 3'd7, 5'd7));
        send_instr(itype_word(12'h004, 5'd1, 3'd1, 5'd10));
        send_instr(itype_word(12'h008, 5'd2, 3'd5, 5'd11));
        send_instr(itype_word({7'h20, 5'd8}, 5'd2, 3'd5, 5'd12));
        // dependent chain, each reads the previous result.
        send_instr(itype_word(12'h001, 5'd13, 3'd0, 5'd13));
        send_instr(itype_word(12'h001, 5'd13, 3'd0, 5'd13));
        send_instr(itype_word(12'h001, 5'd13, 3'd0, 5'd13));
        send_instr(rtype_word(7'h00, 5'd13, 5'd13, 3'd0, 5'd14));
        send_instr(rtype_word(7'h20, 5'd2, 5'd14, 3'd0, 5'd15));
        // illegal encodings leave x16 untouched.
        send_instr(itype_word(12'h055, 5'd0, 3'd0, 5'd16));
        send_instr(rtype_word(7'h01, 5'd1, 5'd2, 3'd0, 5'd16));
        send_instr(itype_word({7'h20, 5'd3}, 5'd1, 3'd1, 5'd16));
        send_instr({12'h000, 5'd1, 3'd2, 5'd16, 7'h03});
        send_instr(rtype_word(7'h00, 5'd0, 5'd16, 3'd0, 5'd17));
        send_instr(itype_word(12'h005, 5'd0, 3'd0, 5'd0));
        send_instr(rtype_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd18));
        wait_drained(400);

        // back-pressure, sink holds every credit.
        hold = 1'b1;
        hold_wb = 0;
        for (int i = 0; i < queue_depth + wb_credits; i++) begin
            send_instr(itype_word(12'(i + 1), 5'd20, 3'd0, 5'd20));
        end
        repeat (2) @(negedge clk);
        stall_window = 1'b1;
        repeat (10) @(negedge clk);
        stall_window = 1'b0;
        a_hold_bound: assert (hold_wb <= wb_credits) else begin
            errors++;
            $display("CHECK FAILED wb_valid pulses under hold expected %h got %h",
                     wb_credits, hold_wb);
        end
        a_src_empty: assert (src_credits() == 0) else begin
            errors++;
            $display("CHECK FAILED source credits expected %h got %h", 0, src_credits());
        end
        hold = 1'b0;
        wait_drained(400);

        for (int i = 0; i < 80; i++) begin
            send_instr(random_instr());
        end
        wait_drained(1000);

        a_credit_total: assert (credits_back == sent_count) else begin
            errors++;
            $display("CHECK FAILED in_credit pulses expected %h got %h", sent_count, credits_back);
        end
        a_wb_total: assert (wb_seen == sent_count) else begin
            errors++;
            $display("CHECK FAILED wb_valid pulses expected %h got %h", sent_count, wb_seen);
        end

        $display("errors: %0d, sent: %0d, completed: %0d, credits back: %0d",
                 errors, sent_count, wb_seen, credits_back);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/alu_core.sv
`timescale 1ns/100ps
`default_nettype none

module alu_core (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             in_valid,
    input  logic [core_pkg::xlen-1:0]        in_instr,
    output logic                             in_credit,
    output logic                             wb_valid,
    output logic [core_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [core_pkg::xlen-1:0]        wb_data,
    output logic [core_pkg::xlen-1:0]        wb_pc,
    output logic                             wb_illegal,
    input  logic                             wb_credit
);
    import core_pkg::*;

    // decode to queue.
    logic                  push;
    alu_op_e               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    logic                  use_imm;
    logic [xlen-1:0]       pc;

    // queue head to execute.
    logic                  q_valid;
    alu_op_e               q_op;
    logic [reg_addr_w-1:0] q_rd;
    logic [reg_addr_w-1:0] q_rs1;
    logic [reg_addr_w-1:0] q_rs2;
    logic [xlen-1:0]       q_imm;
    logic                  q_use_imm;
    logic [xlen-1:0]       q_pc;
    logic                  pop;

    instr_decode i_instr_decode (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .push     (push),
        .op       (op),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm),
        .use_imm  (use_imm),
        .pc       (pc)
    );

    issue_queue i_issue_queue (
        .clk       (clk),
        .rstn      (rstn),
        .push      (push),
        .op        (op),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .use_imm   (use_imm),
        .pc        (pc),
        .pop       (pop),
        .q_valid   (q_valid),
        .q_op      (q_op),
        .q_rd      (q_rd),
        .q_rs1     (q_rs1),
        .q_rs2     (q_rs2),
        .q_imm     (q_imm),
        .q_use_imm (q_use_imm),
        .q_pc      (q_pc),
        .in_credit (in_credit)
    );

    exec_unit i_exec_unit (
        .clk        (clk),
        .rstn       (rstn),
        .q_valid    (q_valid),
        .q_op       (q_op),
        .q_rd       (q_rd),
        .q_rs1      (q_rs1),
        .q_rs2      (q_rs2),
        .q_imm      (q_imm),
        .q_use_imm  (q_use_imm),
        .q_pc       (q_pc),
        .pop        (pop),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc),
        .wb_illegal (wb_illegal),
        .wb_credit  (wb_credit)
    );

endmodule

`default_nettype wire

// File: src/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             q_valid,
    input  core_pkg::alu_op_e                q_op,
    input  logic [core_pkg::reg_addr_w-1:0]  q_rd,
    input  logic [core_pkg::reg_addr_w-1:0]  q_rs1,
    input  logic [core_pkg::reg_addr_w-1:0]  q_rs2,
    input  logic [core_pkg::xlen-1:0]        q_imm,
    input  logic                             q_use_imm,
    input  logic [core_pkg::xlen-1:0]        q_pc,
    output logic                             pop,
    output logic                             wb_valid,
    output logic [core_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [core_pkg::xlen-1:0]        wb_data,
    output logic [core_pkg::xlen-1:0]        wb_pc,
    output logic                             wb_illegal,
    input  logic                             wb_credit
);
    import core_pkg::*;

    logic [wb_cnt_w-1:0] credit_cnt;
    logic [xlen-1:0]     rs1_data;
    logic [xlen-1:0]     rs2_data;
    logic [xlen-1:0]     operand_b;
    logic [xlen-1:0]     alu_result;
    logic                rf_we;

    // issue whenever the head is valid and the sink has room.
    assign pop = q_valid && (credit_cnt != '0);

    assign operand_b = q_use_imm ? q_imm : rs2_data;

    // no write for x0 or an illegal op.
    assign rf_we = pop && (q_rd != '0) && (q_op != alu_illegal);

    reg_file i_reg_file (
        .clk      (clk),
        .rstn     (rstn),
        .rs1      (q_rs1),
        .rs2      (q_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .wd_addr  (q_rd),
        .wd_data  (alu_result)
    );

    alu i_alu (
        .op     (q_op),
        .a      (rs1_data),
        .b      (operand_b),
        .result (alu_result)
    );

    // writeback credit counter.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit_cnt <= wb_credits;
        end else begin
            case ({pop, wb_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= pop;
        end
    end

    // result payload, held until the next pop.
    always_ff @(posedge clk) begin
        if (pop) begin
            wb_rd      <= q_rd;
            wb_data    <= alu_result;
            wb_pc      <= q_pc;
            wb_illegal <= (q_op == alu_illegal);
        end
    end

    // sink returns at most what it was given.
    a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
        credit_cnt <= wb_credits)
        else $error("writeback credit count above limit");

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  core_pkg::alu_op_e          op,
    input  logic [core_pkg::xlen-1:0]  a,
    input  logic [core_pkg::xlen-1:0]  b,
    output logic [core_pkg::xlen-1:0]  result
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shift amount from the low five bits.
    assign shamt = b[4:0];

    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            // illegal encodings produce zero.
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [core_pkg::reg_addr_w-1:0]  rs1,
    input  logic [core_pkg::reg_addr_w-1:0]  rs2,
    output logic [core_pkg::xlen-1:0]        rs1_data,
    output logic [core_pkg::xlen-1:0]        rs2_data,
    input  logic                             we,
    input  logic [core_pkg::reg_addr_w-1:0]  wd_addr,
    input  logic [core_pkg::xlen-1:0]        wd_data
);
    import core_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    // architectural state starts at zero.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wd_addr != '0)) begin
            regs[wd_addr] <= wd_data;
        end
    end

    // x0 is hardwired to zero.
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // execute unit filters x0 writes before they get here.
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rstn)
        we |-> (wd_addr != '0))
        else $error("register file write to x0");

endmodule

`default_nettype wire

// File: src/issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module issue_queue (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             push,
    input  core_pkg::alu_op_e                op,
    input  logic [core_pkg::reg_addr_w-1:0]  rd,
    input  logic [core_pkg::reg_addr_w-1:0]  rs1,
    input  logic [core_pkg::reg_addr_w-1:0]  rs2,
    input  logic [core_pkg::xlen-1:0]        imm,
    input  logic                             use_imm,
    input  logic [core_pkg::xlen-1:0]        pc,
    input  logic                             pop,
    output logic                             q_valid,
    output core_pkg::alu_op_e                q_op,
    output logic [core_pkg::reg_addr_w-1:0]  q_rd,
    output logic [core_pkg::reg_addr_w-1:0]  q_rs1,
    output logic [core_pkg::reg_addr_w-1:0]  q_rs2,
    output logic [core_pkg::xlen-1:0]        q_imm,
    output logic                             q_use_imm,
    output logic [core_pkg::xlen-1:0]        q_pc,
    output logic                             in_credit
);
    import core_pkg::*;

    alu_op_e               op_mem      [queue_depth];
    logic [reg_addr_w-1:0] rd_mem      [queue_depth];
    logic [reg_addr_w-1:0] rs1_mem     [queue_depth];
    logic [reg_addr_w-1:0] rs2_mem     [queue_depth];
    logic [xlen-1:0]       imm_mem     [queue_depth];
    logic                  use_imm_mem [queue_depth];
    logic [xlen-1:0]       pc_mem      [queue_depth];

    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_cnt_w-1:0] count;

    // entry storage, written at the tail.
    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]      <= op;
            rd_mem[wr_ptr]      <= rd;
            rs1_mem[wr_ptr]     <= rs1;
            rs2_mem[wr_ptr]     <= rs2;
            imm_mem[wr_ptr]     <= imm;
            use_imm_mem[wr_ptr] <= use_imm;
            pc_mem[wr_ptr]      <= pc;
        end
    end

    // pointers wrap naturally, depth is a power of two.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back to the source per freed entry.
            in_credit <= pop;
        end
    end

    // head entry.
    assign q_valid   = (count != '0);
    assign q_op      = op_mem[rd_ptr];
    assign q_rd      = rd_mem[rd_ptr];
    assign q_rs1     = rs1_mem[rd_ptr];
    assign q_rs2     = rs2_mem[rd_ptr];
    assign q_imm     = imm_mem[rd_ptr];
    assign q_use_imm = use_imm_mem[rd_ptr];
    assign q_pc      = pc_mem[rd_ptr];

    // source must respect its credits.
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> (count != queue_depth))
        else $error("issue queue push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> (count != '0))
        else $error("issue queue pop while empty");

endmodule

`default_nettype wire

// File: src/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             in_valid,
    input  logic [core_pkg::xlen-1:0]        in_instr,
    output logic                             push,
    output core_pkg::alu_op_e                op,
    output logic [core_pkg::reg_addr_w-1:0]  rd,
    output logic [core_pkg::reg_addr_w-1:0]  rs1,
    output logic [core_pkg::reg_addr_w-1:0]  rs2,
    output logic [core_pkg::xlen-1:0]        imm,
    output logic                             use_imm,
    output logic [core_pkg::xlen-1:0]        pc
);
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] pc_q;

    // instruction fields.
    assign opcode = in_instr[6:0];
    assign funct3 = in_instr[14:12];
    assign funct7 = in_instr[31:25];
    assign rd     = in_instr[11:7];
    assign rs1    = in_instr[19:15];
    assign rs2    = in_instr[24:20];

    // i-type immediate, sign extended.
    assign imm = {{(xlen-12){in_instr[31]}}, in_instr[31:20]};

    assign use_imm = (opcode == opcode_op_imm);
    assign push    = in_valid;
    assign pc      = pc_q;

    always_comb begin
        op = alu_illegal;
        if (opcode == opcode_op) begin
            if (funct7 == funct7_base) begin
                case (funct3)
                    3'b000: op = alu_add;
                    3'b001: op = alu_sll;
                    3'b010: op = alu_slt;
                    3'b011: op = alu_sltu;
                    3'b100: op = alu_xor;
                    3'b101: op = alu_srl;
                    3'b110: op = alu_or;
                    default: op = alu_and;
                endcase
            end else if (funct7 == funct7_alt) begin
                // only sub and sra have an alternate form.
                case (funct3)
                    3'b000: op = alu_sub;
                    3'b101: op = alu_sra;
                    default: op = alu_illegal;
                endcase
            end
        end else if (opcode == opcode_op_imm) begin
            case (funct3)
                3'b000: op = alu_add;
                3'b010: op = alu_slt;
                3'b011: op = alu_sltu;
                3'b100: op = alu_xor;
                3'b110: op = alu_or;
                3'b111: op = alu_and;
                3'b001: begin
                    if (funct7 == funct7_base) begin
                        op = alu_sll;
                    end
                end
                default: begin
                    // shift right immediate, funct7 picks logical or arithmetic.
                    if (funct7 == funct7_base) begin
                        op = alu_srl;
                    end else if (funct7 == funct7_alt) begin
                        op = alu_sra;
                    end
                end
            endcase
        end
    end

    // pc of the next accepted instruction.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q <= '0;
        end else if (in_valid) begin
            pc_q <= pc_q + pc_step;
        end
    end

endmodule

`default_nettype wire

// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

    // data path and pc width.
    localparam int xlen = 32;

    // architectural register file.
    localparam int reg_addr_w = 5;
    localparam int num_regs = 32;

    // issue queue sizing, depth is also the initial source credit count.
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = 2;
    localparam int queue_cnt_w = 3;

    // writeback credits held by the execute unit after reset.
    localparam int wb_cnt_w = 2;
    localparam logic [wb_cnt_w-1:0] wb_credits = 2'd2;

    // pc advance per accepted instruction.
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // rv32i major opcodes handled here.
    localparam logic [6:0] opcode_op = 7'h33;
    localparam logic [6:0] opcode_op_imm = 7'h13;

    // funct7 values for the base and alternate forms.
    localparam logic [6:0] funct7_base = 7'h00;
    localparam logic [6:0] funct7_alt = 7'h20;

    // alu operation, carried from decode to execute.
    typedef enum logic [3:0] {
        alu_add     = 4'd0,
        alu_sub     = 4'd1,
        alu_and     = 4'd2,
        alu_or      = 4'd3,
        alu_xor     = 4'd4,
        alu_slt     = 4'd5,
        alu_sltu    = 4'd6,
        alu_sll     = 4'd7,
        alu_srl     = 4'd8,
        alu_sra     = 4'd9,
        alu_illegal = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire
